// File: hdl/iq_macros.svh
`ifndef IQ_MACROS_SVH
`define IQ_MACROS_SVH

// issue queue sizing
`define ISSUE_QUEUE_DEPTH 8
`define ISSUE_QUEUE_LOG   3

// physical register file sizing
`define PREG_NUM 32
`define PREG_LOG 5

// reorder buffer index width
`define ROB_SIZE_LOG 4

`endif

// File: hdl/iq_pkg.sv
`default_nettype none

`include "iq_macros.svh"

package iq_pkg;

    typedef logic [`PREG_LOG-1:0]     preg_t;
    typedef logic [`ROB_SIZE_LOG-1:0] robidx_t;
    typedef logic [63:0]              xlen_t;
    typedef logic [31:0]              instr_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, ILLEGAL
    } alu_op_e;

    // renamed instruction as it leaves the front end
    typedef struct packed {
        instr_t  instr;
        xlen_t   pc;
        preg_t   prs1;
        preg_t   prs2;
        preg_t   prd;
        logic    robidx_flag;
        robidx_t robidx;
    } dispatch_t;

    typedef struct packed {
        preg_t   prs1;
        preg_t   prs2;
        preg_t   prd;
        logic    robidx_flag;
        robidx_t robidx;
        logic    src1_is_reg;
        logic    src2_is_reg;
        logic    need_to_wb;
        alu_op_e alu_op;
        logic    is_word;
        logic    is_imm;
        xlen_t   imm;
        xlen_t   pc;
    } uop_t;

    // micro-op with resolved operands
    typedef struct packed {
        uop_t  uop;
        xlen_t src1;
        xlen_t src2;
    } exec_t;

    typedef struct packed {
        logic    robidx_flag;
        robidx_t robidx;
        preg_t   prd;
        logic    need_to_wb;
        xlen_t   value;
    } complete_t;

endpackage

`default_nettype wire

// File: hdl/uop_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module uop_decoder import iq_pkg::*; (
    input  dispatch_t dispatch,
    output uop_t      uop
);

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    xlen_t      imm_i;
    xlen_t      shamt;
    alu_op_e    op;
    logic       word;
    logic       imm_sel;
    logic       shift_imm;
    logic       src2_reg;
    logic       legal;

    assign opcode = dispatch.instr[6:0];
    assign funct3 = dispatch.instr[14:12];
    assign funct7 = dispatch.instr[31:25];
    assign funct6 = dispatch.instr[31:26];

    // I-type immediate, sign extended
    assign imm_i = {{52{dispatch.instr[31]}}, dispatch.instr[31:20]};
    // shift amount, word forms only ever see bit 25 clear
    assign shamt = {58'b0, dispatch.instr[25:20]};

    always_comb begin
        op        = ILLEGAL;
        word      = 1'b0;
        imm_sel   = 1'b0;
        shift_imm = 1'b0;
        src2_reg  = 1'b0;
        case (opcode)
            OPC_OP: begin
                src2_reg = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op = ADD;
                    {7'h20, 3'b000}: op = SUB;
                    {7'h00, 3'b001}: op = SLL;
                    {7'h00, 3'b010}: op = SLT;
                    {7'h00, 3'b011}: op = SLTU;
                    {7'h00, 3'b100}: op = XOR;
                    {7'h00, 3'b101}: op = SRL;
                    {7'h20, 3'b101}: op = SRA;
                    {7'h00, 3'b110}: op = OR;
                    {7'h00, 3'b111}: op = AND;
                    default:         op = ILLEGAL;
                endcase
            end
            OPC_OP_IMM: begin
                imm_sel = 1'b1;
                case (funct3)
                    3'b000: op = ADD;
                    3'b010: op = SLT;
                    3'b011: op = SLTU;
                    3'b100: op = XOR;
                    3'b110: op = OR;
                    3'b111: op = AND;
                    3'b001: begin
                        shift_imm = 1'b1;
                        if (funct6 == 6'h00) op = SLL;
                    end
                    default: begin
                        // funct3 101, the right shifts
                        shift_imm = 1'b1;
                        if (funct6 == 6'h00) op = SRL;
                        else if (funct6 == 6'h10) op = SRA;
                    end
                endcase
            end
            OPC_OP_32: begin
                word     = 1'b1;
                src2_reg = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: op = ADD;
                    {7'h20, 3'b000}: op = SUB;
                    {7'h00, 3'b001}: op = SLL;
                    {7'h00, 3'b101}: op = SRL;
                    {7'h20, 3'b101}: op = SRA;
                    default:         op = ILLEGAL;
                endcase
            end
            OPC_OP_IMM_32: begin
                word    = 1'b1;
                imm_sel = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b001}: op = SLL;
                    {7'h00, 3'b101}: op = SRL;
                    {7'h20, 3'b101}: op = SRA;
                    default: if (funct3 == 3'b000) op = ADD;
                endcase
                shift_imm = (funct3 != 3'b000);
            end
            default: op = ILLEGAL;
        endcase
    end

    assign legal = (op != ILLEGAL);

    // illegal ops read nothing and write nothing
    always_comb begin
        uop.prs1        = dispatch.prs1;
        uop.prs2        = dispatch.prs2;
        uop.prd         = dispatch.prd;
        uop.robidx_flag = dispatch.robidx_flag;
        uop.robidx      = dispatch.robidx;
        uop.src1_is_reg = legal;
        uop.src2_is_reg = legal & src2_reg;
        uop.need_to_wb  = legal;
        uop.alu_op      = op;
        uop.is_word     = legal & word;
        uop.is_imm      = legal & imm_sel;
        uop.imm         = shift_imm ? shamt : imm_i;
        uop.pc          = dispatch.pc;
    end

endmodule

`default_nettype wire

// File: hdl/issue_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module issue_queue import iq_pkg::*; (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  enq_valid,
    input  uop_t  enq_uop,
    output logic  enq_ready,
    output logic  busy_set,
    output preg_t busy_set_tag,
    output preg_t rd_tag1,
    output preg_t rd_tag2,
    input  logic  busy1,
    input  logic  busy2,
    input  xlen_t rdata1,
    input  xlen_t rdata2,
    output logic  issue_valid,
    output exec_t issue
);

    uop_t                          queue_uop [`ISSUE_QUEUE_DEPTH];
    logic [`ISSUE_QUEUE_DEPTH-1:0] queue_valid;

    logic [`ISSUE_QUEUE_LOG-1:0] head;
    logic [`ISSUE_QUEUE_LOG-1:0] tail;
    logic                        head_flag;
    logic                        tail_flag;

    logic  enq_fire;
    logic  head_ready;
    uop_t  head_uop;
    xlen_t src1;
    xlen_t src2;

    // tail slot free means room to enqueue
    assign enq_ready = ~queue_valid[tail];
    assign enq_fire  = enq_valid & enq_ready;

    // destination goes busy as soon as it is accepted
    assign busy_set     = enq_fire & enq_uop.need_to_wb;
    assign busy_set_tag = enq_uop.prd;

    assign head_uop = queue_uop[head];
    assign rd_tag1  = head_uop.prs1;
    assign rd_tag2  = head_uop.prs2;

    // in-order, only the head may leave
    assign head_ready = queue_valid[head]
                      & ~(head_uop.src1_is_reg & busy1)
                      & ~(head_uop.src2_is_reg & busy2);

    // operand select, immediate overrides source 2
    assign src1 = head_uop.src1_is_reg ? rdata1 : '0;
    always_comb begin
        if (head_uop.is_imm) begin
            src2 = head_uop.imm;
        end else if (head_uop.src2_is_reg) begin
            src2 = rdata2;
        end else begin
            src2 = '0;
        end
    end

    // pointers with wrap flags
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head      <= '0;
            head_flag <= 1'b0;
            tail      <= '0;
            tail_flag <= 1'b0;
        end else begin
            if (enq_fire) begin
                {tail_flag, tail} <= {tail_flag, tail} + 1'b1;
            end
            if (head_ready) begin
                {head_flag, head} <= {head_flag, head} + 1'b1;
            end
        end
    end

    // head and tail never alias when both fire
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            queue_valid <= '0;
        end else begin
            if (enq_fire) begin
                queue_valid[tail] <= 1'b1;
            end
            if (head_ready) begin
                queue_valid[head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (enq_fire) begin
            queue_uop[tail] <= enq_uop;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= head_ready;
        end
    end

    always_ff @(posedge clock) begin
        if (head_ready) begin
            issue.uop  <= head_uop;
            issue.src1 <= src1;
            issue.src2 <= src2;
        end
    end

endmodule

`default_nettype wire

// File: hdl/preg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module preg_file import iq_pkg::*; (
    input  logic  clock,
    input  logic  reset_n,
    input  preg_t rd_tag1,
    input  preg_t rd_tag2,
    output xlen_t rdata1,
    output xlen_t rdata2,
    output logic  busy1,
    output logic  busy2,
    input  logic  busy_set,
    input  preg_t busy_set_tag,
    input  logic  wb_en,
    input  preg_t wb_tag,
    input  xlen_t wb_data
);

    xlen_t                regs [`PREG_NUM];
    logic [`PREG_NUM-1:0] busy;
    logic                 wr_fire;
    logic                 set_fire;

    // tag 0 is the zero register
    assign wr_fire  = wb_en & (wb_tag != '0);
    assign set_fire = busy_set & (busy_set_tag != '0);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_fire) begin
            regs[wb_tag] <= wb_data;
        end
    end

    // set after clear so a same-tag collision leaves it busy
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy <= '0;
        end else begin
            if (wr_fire) begin
                busy[wb_tag] <= 1'b0;
            end
            if (set_fire) begin
                busy[busy_set_tag] <= 1'b1;
            end
        end
    end

    assign rdata1 = (rd_tag1 == '0) ? '0 : regs[rd_tag1];
    assign rdata2 = (rd_tag2 == '0) ? '0 : regs[rd_tag2];

    assign busy1 = busy[rd_tag1];
    assign busy2 = busy[rd_tag2];

endmodule

`default_nettype wire

// File: hdl/int_alu.sv
`timescale 1ns/1ps
`default_nettype none

module int_alu import iq_pkg::*; (
    input  logic  clock,
    input  logic  reset_n,
    input  logic  issue_valid,
    input  exec_t issue,
    output logic  alu_valid,
    output uop_t  alu_uop,
    output xlen_t alu_result
);

    xlen_t       a;
    xlen_t       b;
    logic [5:0]  shamt;
    logic [31:0] srl_word;
    logic [31:0] sra_word;
    xlen_t       sra_long;
    xlen_t       result;

    assign a = issue.src1;
    assign b = issue.src2;

    // word forms shift by 5 bits only
    assign shamt = issue.uop.is_word ? {1'b0, b[4:0]} : b[5:0];

    assign srl_word = a[31:0] >> shamt;
    assign sra_word = $signed(a[31:0]) >>> shamt;
    assign sra_long = $signed(a) >>> shamt;

    // upper half of word results is fixed up in writeback
    always_comb begin
        case (issue.uop.alu_op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {63'b0, $signed(a) < $signed(b)};
            SLTU:    result = {63'b0, a < b};
            XOR:     result = a ^ b;
            SRL:     result = issue.uop.is_word ? {32'b0, srl_word} : a >> shamt;
            SRA:     result = issue.uop.is_word ? {32'b0, sra_word} : sra_long;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            alu_valid <= 1'b0;
        end else begin
            alu_valid <= issue_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            alu_uop    <= issue.uop;
            alu_result <= result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/result_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module result_writeback import iq_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      alu_valid,
    input  uop_t      alu_uop,
    input  xlen_t     alu_result,
    output logic      complete_valid,
    output complete_t complete,
    output logic      wb_en,
    output preg_t     wb_tag,
    output xlen_t     wb_data
);

    xlen_t value;

    // word results sign extend from bit 31
    assign value = alu_uop.is_word ? {{32{alu_result[31]}}, alu_result[31:0]} : alu_result;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= alu_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (alu_valid) begin
            complete.robidx_flag <= alu_uop.robidx_flag;
            complete.robidx      <= alu_uop.robidx;
            complete.prd         <= alu_uop.prd;
            complete.need_to_wb  <= alu_uop.need_to_wb;
            complete.value       <= value;
        end
    end

    // register write alongside the completion pulse
    assign wb_en   = complete_valid & complete.need_to_wb & (complete.prd != '0);
    assign wb_tag  = complete.prd;
    assign wb_data = complete.value;

endmodule

`default_nettype wire

// File: hdl/int_backend_top.sv
`timescale 1ns/1ps
`default_nettype none

module int_backend_top import iq_pkg::*; (
    input  logic      clock,
    input  logic      reset_n,
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,
    output logic      complete_valid,
    output complete_t complete
);

    uop_t  dec_uop;
    logic  busy_set;
    preg_t busy_set_tag;
    preg_t rd_tag1;
    preg_t rd_tag2;
    xlen_t rdata1;
    xlen_t rdata2;
    logic  busy1;
    logic  busy2;
    logic  issue_valid;
    exec_t issue;
    logic  alu_valid;
    uop_t  alu_uop;
    xlen_t alu_result;
    logic  wb_en;
    preg_t wb_tag;
    xlen_t wb_data;

    uop_decoder uop_decoder_inst (
        .dispatch (dispatch),
        .uop      (dec_uop)
    );

    issue_queue issue_queue_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .enq_valid    (dispatch_valid),
        .enq_uop      (dec_uop),
        .enq_ready    (dispatch_ready),
        .busy_set     (busy_set),
        .busy_set_tag (busy_set_tag),
        .rd_tag1      (rd_tag1),
        .rd_tag2      (rd_tag2),
        .busy1        (busy1),
        .busy2        (busy2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .issue_valid  (issue_valid),
        .issue        (issue)
    );

    preg_file preg_file_inst (
        .clock        (clock),
        .reset_n      (reset_n),
        .rd_tag1      (rd_tag1),
        .rd_tag2      (rd_tag2),
        .rdata1       (rdata1),
        .rdata2       (rdata2),
        .busy1        (busy1),
        .busy2        (busy2),
        .busy_set     (busy_set),
        .busy_set_tag (busy_set_tag),
        .wb_en        (wb_en),
        .wb_tag       (wb_tag),
        .wb_data      (wb_data)
    );

    int_alu int_alu_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .issue_valid (issue_valid),
        .issue       (issue),
        .alu_valid   (alu_valid),
        .alu_uop     (alu_uop),
        .alu_result  (alu_result)
    );

    result_writeback result_writeback_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .alu_valid      (alu_valid),
        .alu_uop        (alu_uop),
        .alu_result     (alu_result),
        .complete_valid (complete_valid),
        .complete       (complete),
        .wb_en          (wb_en),
        .wb_tag         (wb_tag),
        .wb_data        (wb_data)
    );

endmodule

`default_nettype wire

// File: verif/int_backend_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module int_backend_chk import iq_pkg::*; (
    input logic                        clock,
    input logic                        reset_n,
    input logic                        enq_ready,
    input logic [`ISSUE_QUEUE_LOG-1:0] head,
    input logic [`ISSUE_QUEUE_LOG-1:0] tail,
    input logic                        head_flag,
    input logic                        tail_flag,
    input uop_t                        head_uop,
    input logic                        busy1,
    input logic                        busy2,
    input logic                        issue_valid
);

    // same slot on the other lap means full
    no_enq_when_full: assert property (
        @(posedge clock) disable iff (!reset_n)
        (head == tail) && (head_flag != tail_flag) |-> !enq_ready
    ) else $error("enq_ready high while the queue is full");

    issue_idle_after_reset: assert property (
        @(posedge clock) $rose(reset_n) |-> !issue_valid
    ) else $error("issue_valid high right after reset");

    // head waiting on a busy source stays put
    issue_sources_idle: assert property (
        @(posedge clock) disable iff (!reset_n)
        (head_uop.src1_is_reg && busy1) || (head_uop.src2_is_reg && busy2) |=> !issue_valid
    ) else $error("head issued while a register source was busy");

endmodule

bind issue_queue int_backend_chk int_backend_chk_inst (
    .clock       (clock),
    .reset_n     (reset_n),
    .enq_ready   (enq_ready),
    .head        (head),
    .tail        (tail),
    .head_flag   (head_flag),
    .tail_flag   (tail_flag),
    .head_uop    (head_uop),
    .busy1       (busy1),
    .busy2       (busy2),
    .issue_valid (issue_valid)
);

`default_nettype wire

// File: verif/int_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iq_macros.svh"

module int_backend_tb
    import iq_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    // dependency chain longer than the queue
    localparam int CHAIN_LEN  = `ISSUE_QUEUE_DEPTH + 3;
    localparam int FIXED_ROWS = 21;
    localparam int NUM_ROWS   = FIXED_ROWS + CHAIN_LEN;

    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;

    logic      clock;
    logic      reset_n;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic      dispatch_ready;
    logic      complete_valid;
    complete_t complete;

    // stimulus table with expected completions
    dispatch_t row_disp [NUM_ROWS];
    xlen_t     row_exp  [NUM_ROWS];
    logic      row_wb   [NUM_ROWS];
    string     row_name [NUM_ROWS];

    // architectural view of the physical registers
    xlen_t  ref_regs [`PREG_NUM];
    int     nrows;
    int     comp_count;
    int     errors;
    int     passed;
    integer seed;
    logic   accepted;
    logic   ready_low_seen;

    int_backend_top int_backend_top_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .complete_valid (complete_valid),
        .complete       (complete)
    );

    function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {f7, 10'b0, f3, 5'b0, opc};
    endfunction

    function automatic instr_t i_type(input logic [11:0] imm, input logic [2:0] f3,
                                      input logic [6:0] opc);
        return {imm, 5'b0, f3, 5'b0, opc};
    endfunction

    // RV64I semantics, bit 64 set when the encoding is supported
    function automatic logic [64:0] ref_exec(input instr_t instr, input xlen_t a, input xlen_t b);
        logic [6:0] opc;
        logic       imm_form;
        logic       word_form;
        logic       ok;
        logic [5:0] sh;
        xlen_t      op2;
        xlen_t      res;
        opc       = instr[6:0];
        imm_form  = (opc == OPC_OP_IMM) || (opc == OPC_OP_IMM_32);
        word_form = (opc == OPC_OP_32) || (opc == OPC_OP_IMM_32);
        ok        = imm_form || word_form || (opc == OPC_OP);
        op2       = imm_form ? {{52{instr[31]}}, instr[31:20]} : b;
        sh        = word_form ? {1'b0, op2[4:0]} : op2[5:0];
        case (instr[14:12])
            3'b000: res = (instr[30] && !imm_form) ? a - op2 : a + op2;
            3'b001: res = a << sh;
            3'b010: res = ($signed(a) < $signed(op2)) ? 64'd1 : 64'd0;
            3'b011: res = (a < op2) ? 64'd1 : 64'd0;
            3'b100: res = a ^ op2;
            3'b101: begin
                if (word_form && instr[30]) begin
                    res = $signed(a[31:0]) >>> sh;
                end else if (word_form) begin
                    res = a[31:0] >> sh;
                end else if (instr[30]) begin
                    res = $signed(a) >>> sh;
                end else begin
                    res = a >> sh;
                end
            end
            3'b110: res = a | op2;
            default: res = a & op2;
        endcase
        if (word_form) begin
            res = {{32{res[31]}}, res[31:0]};
        end
        if (!ok) begin
            res = '0;
        end
        return {ok, res};
    endfunction

    task automatic add_row(input string name, input instr_t instr, input preg_t rs1,
                           input preg_t rs2, input preg_t rd);
        logic [64:0] r;
        dispatch_t   d;
        r       = ref_exec(instr, ref_regs[rs1], ref_regs[rs2]);
        d.instr = instr;
        d.pc    = 64'h1000 + xlen_t'(nrows) * 4;
        d.prs1  = rs1;
        d.prs2  = rs2;
        d.prd   = rd;
        {d.robidx_flag, d.robidx} = nrows[`ROB_SIZE_LOG:0];
        row_disp[nrows] = d;
        row_exp[nrows]  = r[63:0];
        row_wb[nrows]   = r[64];
        row_name[nrows] = name;
        if (r[64] && rd != '0) begin
            ref_regs[rd] = r[63:0];
        end
        nrows++;
    endtask

    task automatic build_table();
        preg_t       prev;
        preg_t       rd;
        logic [31:0] rnd;
        int          pick;
        for (int i = 0; i < `PREG_NUM; i++) begin
            ref_regs[i] = '0;
        end
        add_row("addi", i_type(12'd100, 3'b000, OPC_OP_IMM), 5'd0, 5'd0, 5'd1);
        add_row("addi neg", i_type(12'hff9, 3'b000, OPC_OP_IMM), 5'd0, 5'd0, 5'd2);
        add_row("add", r_type(7'h00, 3'b000, OPC_OP), 5'd1, 5'd2, 5'd3);
        add_row("sub", r_type(7'h20, 3'b000, OPC_OP), 5'd2, 5'd1, 5'd4);
        add_row("slli", i_type(12'd3, 3'b001, OPC_OP_IMM), 5'd1, 5'd0, 5'd5);
        add_row("srli", i_type(12'd4, 3'b101, OPC_OP_IMM), 5'd2, 5'd0, 5'd6);
        add_row("srai", i_type(12'h401, 3'b101, OPC_OP_IMM), 5'd2, 5'd0, 5'd7);
        add_row("slt", r_type(7'h00, 3'b010, OPC_OP), 5'd2, 5'd1, 5'd8);
        add_row("sltu", r_type(7'h00, 3'b011, OPC_OP), 5'd2, 5'd1, 5'd9);
        add_row("xori", i_type(12'h0f0, 3'b100, OPC_OP_IMM), 5'd1, 5'd0, 5'd10);
        add_row("or", r_type(7'h00, 3'b110, OPC_OP), 5'd1, 5'd2, 5'd11);
        add_row("and", r_type(7'h00, 3'b111, OPC_OP), 5'd1, 5'd2, 5'd12);
        add_row("sll", r_type(7'h00, 3'b001, OPC_OP), 5'd2, 5'd1, 5'd13);
        add_row("addw", r_type(7'h00, 3'b000, OPC_OP_32), 5'd6, 5'd1, 5'd14);
        add_row("slliw", i_type(12'd25, 3'b001, OPC_OP_IMM_32), 5'd1, 5'd0, 5'd15);
        add_row("sraw", r_type(7'h20, 3'b101, OPC_OP_32), 5'd15, 5'd2, 5'd16);
        add_row("subw", r_type(7'h20, 3'b000, OPC_OP_32), 5'd1, 5'd5, 5'd17);
        // a load is outside this back end and must leave tag 17 untouched
        add_row("illegal", i_type(12'd8, 3'b011, OPC_LOAD), 5'd0, 5'd0, 5'd17);
        add_row("read illegal prd", r_type(7'h00, 3'b000, OPC_OP), 5'd17, 5'd1, 5'd19);
        add_row("write tag 0", i_type(12'd5, 3'b000, OPC_OP_IMM), 5'd1, 5'd0, 5'd0);
        add_row("read tag 0", r_type(7'h00, 3'b000, OPC_OP), 5'd0, 5'd1, 5'd20);
        // random operands along a serial chain
        prev = 5'd20;
        for (int k = 0; k < CHAIN_LEN; k++) begin
            rd = preg_t'(21 + k);
            if (k % 2 == 0) begin
                rnd = $random(seed);
                add_row("chain addi", i_type(rnd[11:0], 3'b000, OPC_OP_IMM), prev, 5'd0, rd);
            end else begin
                pick = $unsigned($random(seed)) % 19 + 1;
                add_row("chain xor", r_type(7'h00, 3'b100, OPC_OP), prev, preg_t'(pick), rd);
            end
            prev = rd;
        end
    endtask

    task automatic check_completion(input int k);
        dispatch_t d;
        int        errors_before;
        d             = row_disp[k];
        errors_before = errors;
        assert ({complete.robidx_flag, complete.robidx} == {d.robidx_flag, d.robidx})
        else begin
            $display("CHECK FAILED at %0t: test %0d expected robidx %0d, got %0d",
                     $time, k, d.robidx, complete.robidx);
            errors++;
        end
        assert (complete.value == row_exp[k] && complete.need_to_wb == row_wb[k]
                && complete.prd == d.prd)
        else begin
            $display("CHECK FAILED at %0t: test %0d %s exp %h/%0b/%0d got %h/%0b/%0d",
                     $time, k, row_name[k], row_exp[k], row_wb[k], d.prd,
                     complete.value, complete.need_to_wb, complete.prd);
            errors++;
        end
        if (errors == errors_before) begin
            passed++;
        end
        $display("test %0d %s: robidx %0d value %h %s", k, row_name[k], d.robidx,
                 complete.value, (errors == errors_before) ? "ok" : "bad");
    endtask

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // completions sampled mid-cycle
    always @(negedge clock) begin
        if (reset_n && complete_valid) begin
            if (comp_count >= nrows) begin
                $display("unexpected extra completion at %0t with robidx %0d",
                         $time, complete.robidx);
                errors++;
            end else begin
                check_completion(comp_count);
            end
            comp_count++;
        end
    end

    initial begin
        #(NUM_ROWS * 20 * CLK_PERIOD);
        $display("timeout: only %0d of %0d micro-ops completed", comp_count, NUM_ROWS);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        reset_n        = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        seed           = 49690;
        nrows          = 0;
        comp_count     = 0;
        errors         = 0;
        passed         = 0;
        accepted       = 1'b0;
        ready_low_seen = 1'b0;
        build_table();
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(posedge clock);
        for (int i = 0; i < nrows; i++) begin
            dispatch_valid <= 1'b1;
            dispatch       <= row_disp[i];
            accepted = 1'b0;
            while (!accepted) begin
                @(negedge clock);
                accepted = dispatch_ready;
                if (!accepted) begin
                    ready_low_seen = 1'b1;
                end
                @(posedge clock);
            end
        end
        dispatch_valid <= 1'b0;
        wait (comp_count == nrows);
        repeat (4) @(posedge clock);
        assert (ready_low_seen)
        else begin
            $display("dispatch_ready never dropped while the queue was loaded");
            errors++;
        end
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 nrows, passed, nrows - passed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+hdl
hdl/iq_pkg.sv
hdl/uop_decoder.sv
hdl/issue_queue.sv
hdl/preg_file.sv
hdl/int_alu.sv
hdl/result_writeback.sv
hdl/int_backend_top.sv
verif/int_backend_chk.sv
verif/int_backend_tb.sv

// File: Bender.yml
package:
  name: int_backend

export_include_dirs:
  - hdl

sources:
  - hdl/iq_pkg.sv
  - hdl/uop_decoder.sv
  - hdl/issue_queue.sv
  - hdl/preg_file.sv
  - hdl/int_alu.sv
  - hdl/result_writeback.sv
  - hdl/int_backend_top.sv
  - target: simulation
    files:
      - verif/int_backend_chk.sv
      - verif/int_backend_tb.sv
